//--- prof_pkg.sv
// call profiler shared types: retire trace, decoder events, records and instruction views
package prof_pkg;

	// base opcodes of the two jump instructions
	localparam logic [6:0] OP_JAL  = 7'b1101111;
	localparam logic [6:0] OP_JALR = 7'b1100111;

	localparam logic [4:0] REG_ZERO = 5'd0;
	localparam logic [4:0] REG_RA   = 5'd1; // x1, link register

	// one retired instruction from the core
	typedef struct packed {
		logic        valid;
		logic [31:0] pc;
		logic [31:0] instr;
	} retire_t;

	// J-type layout, immediate bits scattered as in the ISA
	typedef struct packed {
		logic       imm20;
		logic [9:0] imm10_1;
		logic       imm11;
		logic [7:0] imm19_12;
		logic [4:0] rd;
		logic [6:0] opcode;
	} j_fmt_t;

	// I-type layout
	typedef struct packed {
		logic [11:0] imm12;
		logic [4:0]  rs1;
		logic [2:0]  funct3;
		logic [4:0]  rd;
		logic [6:0]  opcode;
	} i_fmt_t;

	// same instruction word seen as jal or as jalr
	typedef union packed {
		j_fmt_t j;
		i_fmt_t i;
	} instr_u;

	// decoder output, one per retired instruction
	typedef struct packed {
		logic        call;
		logic        retn;
		logic        inst;   // any retired instruction
		logic [31:0] target; // call target, held between calls
	} call_evt_t;

	// one record per finished invocation
	typedef struct packed {
		logic        valid;
		logic [31:0] entry;
		logic [7:0]  depth;
		logic [31:0] count; // inclusive of descendants
	} profile_rec_t;

endpackage

//--- call_decoder.sv
// call decoder: registers each retired instruction as call, return or plain, with call target
`timescale 1ns/100ps

module call_decoder import prof_pkg::*; (
	input  logic      clk,
	input  logic      reset,
	input  retire_t   retire,
	output call_evt_t evt
);

	instr_u      iw;
	logic        is_call;
	logic        is_retn;
	logic [31:0] j_offset;

	assign iw = retire.instr;

	// jal ra, offset
	assign is_call = (iw.j.opcode == OP_JAL) && (iw.j.rd == REG_RA);

	// only the canonical jalr x0, 0(ra) counts as a return
	assign is_retn = (iw.i.opcode == OP_JALR) &&
		(iw.i.rd == REG_ZERO) &&
		(iw.i.rs1 == REG_RA) &&
		(iw.i.imm12 == 12'd0);

	// reassemble the J immediate, sign from bit 31
	assign j_offset = {
		{11{iw.j.imm20}},
		iw.j.imm20,
		iw.j.imm19_12,
		iw.j.imm11,
		iw.j.imm10_1,
		1'b0
	};

	always_ff @(posedge clk) begin
		if (reset) begin
			evt.call <= 1'b0;
			evt.retn <= 1'b0;
			evt.inst <= 1'b0;
		end else begin
			evt.call <= retire.valid && is_call;
			evt.retn <= retire.valid && is_retn;
			evt.inst <= retire.valid; // idle cycles give an empty event
		end
		if (retire.valid && is_call) begin
			evt.target <= retire.pc + j_offset;
		end
	end

endmodule

//--- stack_ram.sv
// stack RAM: inferred memory with registered read address and write-first read
`timescale 1ns/100ps

module stack_ram #(
	parameter int DEPTH  = 32,
	parameter int ADDR_W = 5,
	parameter int W      = 32
) (
	input  logic              clk,
	input  logic              wren,
	input  logic [ADDR_W-1:0] wr_addr,
	input  logic [W-1:0]      wr_data,
	input  logic [ADDR_W-1:0] rd_addr_next,
	output logic [W-1:0]      rd_data
);

	logic [W-1:0]      mem [DEPTH];
	logic [ADDR_W-1:0] rd_addr; // read address register

	always_ff @(posedge clk) begin
		if (wren) begin
			mem[wr_addr] <= wr_data;
		end
		rd_addr <= rd_addr_next;
	end

	// array is read through the registered address after the edge,
	// so a write landing on that address at the same edge shows up at once
	assign rd_data = mem[rd_addr];

endmodule

//--- counter_stack.sv
// counter stack: RAM-backed push on call, clear and pop on return, top entry always on pop_data
`timescale 1ns/100ps

module counter_stack #(
	parameter int STACK_DEPTH = 32,
	parameter int ADDR_W      = 5,
	parameter int CW          = 32
) (
	input  logic            clk,
	input  logic            reset,
	input  logic            call_as_cb,
	input  logic            retn_as_cb,
	input  logic [CW-1:0]   push_data,
	output logic [CW-1:0]   pop_data,
	output logic [ADDR_W:0] depth
);

	logic [ADDR_W:0]   ptr;      // number of saved entries
	logic [ADDR_W:0]   ptr_next;
	logic [ADDR_W:0]   ptr_dec;  // current top entry
	logic [ADDR_W:0]   next_dec; // top entry after this cycle
	logic              wren;
	logic [ADDR_W-1:0] wr_addr;
	logic [CW-1:0]     wr_data;

	always_comb begin
		ptr_next = ptr;
		if (call_as_cb) begin
			ptr_next = ptr + 1'b1;
		end else if (retn_as_cb) begin
			ptr_next = ptr - 1'b1;
		end
	end

	assign ptr_dec  = ptr - 1'b1;
	assign next_dec = ptr_next - 1'b1;

	assign wren    = call_as_cb | retn_as_cb;
	assign wr_addr = retn_as_cb ? ptr_dec[ADDR_W-1:0] : ptr[ADDR_W-1:0];
	assign wr_data = retn_as_cb ? '0 : push_data; // freed slot is cleared

	always_ff @(posedge clk) begin
		if (reset) begin
			ptr <= '0; // first push lands at entry 0
		end else begin
			ptr <= ptr_next;
		end
	end

	// read side follows the new top, the write-first RAM covers a same-cycle push
	stack_ram #(
		.DEPTH  (STACK_DEPTH),
		.ADDR_W (ADDR_W),
		.W      (CW)
	) ram0 (
		.clk          (clk),
		.wren         (wren),
		.wr_addr      (wr_addr),
		.wr_data      (wr_data),
		.rd_addr_next (next_dec[ADDR_W-1:0]),
		.rd_data      (pop_data)
	);

	assign depth = ptr;

endmodule

//--- call_profiler.sv
// call profiler core: inclusive instruction counts per invocation, depth guard, record output
`timescale 1ns/100ps

module call_profiler import prof_pkg::*; #(
	parameter int STACK_DEPTH = 32,
	parameter int ADDR_W      = 5
) (
	input  logic         clk,
	input  logic         reset,
	input  call_evt_t    evt,
	output profile_rec_t rec,
	output logic [7:0]   depth,
	output logic         stack_error
);

	localparam logic [ADDR_W:0] FULL = (ADDR_W + 1)'(STACK_DEPTH);

	logic [ADDR_W:0] stack_depth;
	logic            do_push;   // accepted call
	logic            do_pop;    // accepted return
	logic            bad_call;
	logic            bad_retn;
	logic [31:0]     cur_count; // current invocation, descendants included
	logic [31:0]     cur_entry;
	logic [31:0]     count_inc; // cur_count plus this instruction
	logic [31:0]     pop_count;
	logic [31:0]     pop_entry;

	// depth guard
	assign do_push  = evt.call && (stack_depth != FULL);
	assign do_pop   = evt.retn && (stack_depth != '0);
	assign bad_call = evt.call && !do_push;
	assign bad_retn = evt.retn && !do_pop;

	assign count_inc = cur_count + 32'd1;

	// caller count, the call already counted in it
	counter_stack #(
		.STACK_DEPTH (STACK_DEPTH),
		.ADDR_W      (ADDR_W),
		.CW          (32)
	) count_stack0 (
		.clk        (clk),
		.reset      (reset),
		.call_as_cb (do_push),
		.retn_as_cb (do_pop),
		.push_data  (count_inc),
		.pop_data   (pop_count),
		.depth      (stack_depth)
	);

	// caller entry address, moves in step with the count stack
	counter_stack #(
		.STACK_DEPTH (STACK_DEPTH),
		.ADDR_W      (ADDR_W),
		.CW          (32)
	) entry_stack0 (
		.clk        (clk),
		.reset      (reset),
		.call_as_cb (do_push),
		.retn_as_cb (do_pop),
		.push_data  (cur_entry),
		.pop_data   (pop_entry),
		.depth      ()
	);

	always_ff @(posedge clk) begin
		if (reset) begin
			cur_count <= '0;
		end else if (evt.inst) begin
			if (do_push) begin
				cur_count <= '0; // fresh callee
			end else if (do_pop) begin
				cur_count <= pop_count + count_inc; // callee folds into caller
			end else begin
				cur_count <= count_inc; // plain or rejected call/return
			end
		end
	end

	always_ff @(posedge clk) begin
		if (do_push) begin
			cur_entry <= evt.target;
		end else if (do_pop) begin
			cur_entry <= pop_entry;
		end
	end

	// record carries the callee depth, before the pop
	always_ff @(posedge clk) begin
		if (reset) begin
			rec.valid <= 1'b0;
		end else begin
			rec.valid <= do_pop;
		end
		if (do_pop) begin
			rec.entry <= cur_entry;
			rec.depth <= depth;
			rec.count <= count_inc; // return counts in the callee
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			stack_error <= 1'b0;
		end else if (bad_call || bad_retn) begin
			stack_error <= 1'b1; // sticky until reset
		end
	end

	assign depth = 8'(stack_depth);

endmodule

//--- profiler_top.sv
// call profiler top: decoder stage feeding the profiler core
`timescale 1ns/100ps

module profiler_top import prof_pkg::*; #(
	parameter int STACK_DEPTH = 32,
	parameter int ADDR_W      = 5
) (
	input  logic         clk,
	input  logic         reset,
	input  retire_t      retire,
	output profile_rec_t rec,
	output logic [7:0]   depth,
	output logic         stack_error
);

	call_evt_t evt; // registered, one cycle behind retire

	call_decoder dec0 (
		.clk    (clk),
		.reset  (reset),
		.retire (retire),
		.evt    (evt)
	);

	// record appears one cycle after the event, two after the retired return
	call_profiler #(
		.STACK_DEPTH (STACK_DEPTH),
		.ADDR_W      (ADDR_W)
	) prof0 (
		.clk         (clk),
		.reset       (reset),
		.evt         (evt),
		.rec         (rec),
		.depth       (depth),
		.stack_error (stack_error)
	);

endmodule

//--- profiler_top_sva.sv
// profiler assertions: event exclusivity, reset values, depth stepping and sticky error
`timescale 1ns/100ps

module profiler_top_sva import prof_pkg::*; (
	input logic         clk,
	input logic         reset,
	input call_evt_t    evt,
	input profile_rec_t rec,
	input logic [7:0]   depth,
	input logic         stack_error
);

	logic fail_excl  = 1'b0;
	logic fail_reset = 1'b0;
	logic fail_step  = 1'b0;
	logic fail_stick = 1'b0;
	logic assert_failed;

	assign assert_failed = fail_excl | fail_reset | fail_step | fail_stick;

	// decoder marks one kind of event per instruction
	evt_exclusive: assert property (@(posedge clk) disable iff (reset)
		!(evt.call && evt.retn))
	else begin
		fail_excl = 1'b1;
		$error("call and return events high together");
	end

	// covers the reset cycles and the first cycle after
	reset_values: assert property (@(posedge clk)
		reset |=> (!rec.valid && depth == 8'd0 && !stack_error))
	else begin
		fail_reset = 1'b1;
		$error("record strobe, depth or error not cleared by reset");
	end

	depth_step: assert property (@(posedge clk) disable iff (reset)
		(depth == $past(depth)) || (depth == $past(depth) + 8'd1) ||
		(depth + 8'd1 == $past(depth)))
	else begin
		fail_step = 1'b1;
		$error("depth moved by more than one");
	end

	error_sticky: assert property (@(posedge clk) disable iff (reset)
		$past(stack_error) |-> stack_error)
	else begin
		fail_stick = 1'b1;
		$error("stack error cleared without reset");
	end

endmodule

bind call_profiler profiler_top_sva sva0 (
	.clk         (clk),
	.reset       (reset),
	.evt         (evt),
	.rec         (rec),
	.depth       (depth),
	.stack_error (stack_error)
);

//--- profiler_top_tb.sv
// call profiler testbench checking random call and return programs against a software call stack
`timescale 1ns/100ps

module profiler_top_tb import prof_pkg::*; ();

	localparam int STACK_DEPTH = 32;
	localparam int MAX_NEST    = 8; // random walk stays well below the guard
	localparam int RAND_STEPS  = 300;
	// instructions per test summed and doubled for random idle cycles
	localparam int MAX_INSTR      = 20 + RAND_STEPS + MAX_NEST + 20 + 2 * STACK_DEPTH + 12;
	localparam int TIMEOUT_CYCLES = 2 * MAX_INSTR + 10 + 100;

	// expected outputs for one retired instruction
	typedef struct packed {
		logic [31:0] arrival;   // cycle the outputs must show it
		logic        rec_valid;
		logic [31:0] entry;
		logic [7:0]  rec_depth;
		logic [31:0] count;
		logic [7:0]  depth;
		logic        err;
	} expect_t;

	logic         clk = 1'b0;
	logic         reset;
	retire_t      retire;
	profile_rec_t rec;
	logic [7:0]   depth;
	logic         stack_error;

	int          cycle    = 0;
	int          idle_pct = 0; // chance of an idle cycle before an instruction
	logic [31:0] cur_pc   = 32'h0000_1000;
	expect_t     exp_q[$];

	// reference model state
	int          m_depth = 0;
	logic [31:0] m_count = '0;
	logic [31:0] m_entry = '0;
	logic        m_err   = 1'b0;
	logic [31:0] cnt_stack[$];
	logic [31:0] ent_stack[$];

	logic [7:0] exp_depth = '0; // held between arrivals
	logic       exp_err   = 1'b0;

	profiler_top #(
		.STACK_DEPTH (STACK_DEPTH),
		.ADDR_W      (5)
	) dut0 (
		.clk         (clk),
		.reset       (reset),
		.retire      (retire),
		.rec         (rec),
		.depth       (depth),
		.stack_error (stack_error)
	);

	initial begin
		forever #4 clk = ~clk;
	end

	task automatic end_with_failure();
		$display("*** TEST FAILED ***");
		$fatal(1, "stopped at cycle %0d", cycle);
	endtask

	task automatic check_value(input string name, input logic [31:0] got,
			input logic [31:0] want);
		if (got !== want) begin
			$display("CHECK FAILED %s: got %h, expected %h at cycle %0d", name, got, want, cycle);
			end_with_failure();
		end
	endtask

	always @(posedge clk) begin
		cycle <= cycle + 1;
		if (cycle >= TIMEOUT_CYCLES) begin
			$display("timeout: the run went past %0d cycles", TIMEOUT_CYCLES);
			end_with_failure();
		end
	end

	// software model of one retired instruction
	function automatic expect_t ref_record(input logic [31:0] pc, input logic [31:0] instr);
		expect_t     e;
		logic        is_call;
		logic        is_retn;
		logic [31:0] offset;
		logic [31:0] inclusive;
		e = '0;
		is_call = (instr[6:0] == OP_JAL) && (instr[11:7] == REG_RA);
		is_retn = (instr[6:0] == OP_JALR) && (instr[11:7] == REG_ZERO) &&
			(instr[19:15] == REG_RA) && (instr[31:20] == 12'd0);
		offset = {{12{instr[31]}}, instr[19:12], instr[20], instr[30:21], 1'b0};
		if (is_call && m_depth < STACK_DEPTH) begin
			cnt_stack.push_back(m_count + 32'd1); // call counts in the caller
			ent_stack.push_back(m_entry);
			m_count = '0;
			m_entry = pc + offset;
			m_depth++;
		end else if (is_retn && m_depth > 0) begin
			inclusive   = m_count + 32'd1; // return counts in the callee
			e.rec_valid = 1'b1;
			e.entry     = m_entry;
			e.rec_depth = 8'(m_depth);
			e.count     = inclusive;
			m_count = cnt_stack.pop_back() + inclusive;
			m_entry = ent_stack.pop_back();
			m_depth--;
		end else begin
			if (is_call || is_retn) begin
				m_err = 1'b1; // guard hit but the instruction still counts
			end
			m_count = m_count + 32'd1;
		end
		e.depth = 8'(m_depth);
		e.err   = m_err;
		return e;
	endfunction

	function automatic logic [31:0] enc_jal(input logic [4:0] rd, input logic [20:0] off);
		return {off[20], off[10:1], off[11], off[19:12], rd, OP_JAL};
	endfunction

	function automatic logic [31:0] enc_jalr(input logic [4:0] rd, input logic [4:0] rs1,
			input logic [11:0] imm);
		return {imm, rs1, 3'b000, rd, OP_JALR};
	endfunction

	function automatic logic [31:0] plain_instr();
		logic [31:0] w;
		w = $urandom;
		case ($urandom % 4)
			0: w[6:0] = 7'b0110011;       // register ALU
			1: w[6:0] = 7'b0010011;       // immediate ALU
			2: w[6:0] = 7'b0000011;       // load
			default: w[6:0] = 7'b0100011; // store
		endcase
		return w;
	endfunction

	task automatic idle_one();
		@(posedge clk);
		retire <= '{valid: 1'b0, pc: $urandom, instr: $urandom}; // junk must be ignored
	endtask

	task automatic retire_one(input logic [31:0] instr);
		expect_t e;
		if (($urandom % 100) < idle_pct) begin
			idle_one();
		end
		@(posedge clk);
		retire <= '{valid: 1'b1, pc: cur_pc, instr: instr};
		e = ref_record(cur_pc, instr);
		e.arrival = cycle + 3; // cycle still holds the previous count here
		exp_q.push_back(e);
		cur_pc = cur_pc + 32'd4;
	endtask

	task automatic do_call();
		logic [31:0] r;
		logic [31:0] pc0;
		r   = $urandom;
		pc0 = cur_pc;
		retire_one(enc_jal(REG_RA, {r[20:1], 1'b0}));
		cur_pc = pc0 + {{11{r[20]}}, r[20:1], 1'b0};
	endtask

	task automatic do_return();
		retire_one(enc_jalr(REG_ZERO, REG_RA, 12'd0));
	endtask

	task automatic test_decode();
		idle_pct = 25;
		repeat (4) retire_one(plain_instr());
		retire_one(enc_jal(5'd5, 21'h000104));         // links into t0
		retire_one(enc_jal(REG_ZERO, 21'h1ffff0));     // plain jump
		retire_one(enc_jalr(REG_ZERO, REG_RA, 12'd4)); // nonzero offset
		retire_one(enc_jalr(REG_RA, REG_RA, 12'd0));
		retire_one(enc_jalr(REG_ZERO, 5'd5, 12'd0));   // wrong base
		do_call();
		repeat (3) retire_one(plain_instr());
		do_return();
	endtask

	task automatic test_nesting();
		int unsigned pick;
		idle_pct = 20;
		for (int i = 0; i < RAND_STEPS; i++) begin
			pick = $urandom % 8;
			if (pick < 2 && m_depth < MAX_NEST) begin
				do_call();
			end else if (pick < 4 && m_depth > 0) begin
				do_return();
			end else begin
				retire_one(plain_instr());
			end
		end
		while (m_depth > 0) begin
			do_return();
		end
	endtask

	// adjacent events so the pop sees the push of the previous cycle
	task automatic test_back_to_back();
		idle_pct = 0;
		do_call();
		do_return();
		repeat (6) do_call();
		repeat (6) do_return();
		do_call();
		do_return();
		do_call();
		do_return();
	endtask

	task automatic test_guards();
		idle_pct = 25;
		repeat (STACK_DEPTH + 2) do_call(); // last two are rejected
		retire_one(plain_instr());
		repeat (STACK_DEPTH + 2) do_return(); // last two find an empty stack
		retire_one(plain_instr());
		do_call();
		retire_one(plain_instr());
		do_return();
	endtask

	always @(negedge clk) begin : compare
		expect_t e;
		logic    want_valid;
		want_valid = 1'b0;
		if (dut0.prof0.sva0.assert_failed) begin
			$display("a bound assertion on the profiler failed");
			end_with_failure();
		end
		if (exp_q.size() != 0 && exp_q[0].arrival == cycle) begin
			e = exp_q.pop_front();
			want_valid = e.rec_valid;
			exp_depth  = e.depth;
			exp_err    = e.err;
			if (e.rec_valid) begin
				check_value("rec.entry", rec.entry, e.entry);
				check_value("rec.depth", 32'(rec.depth), 32'(e.rec_depth));
				check_value("rec.count", rec.count, e.count);
			end
		end
		check_value("rec.valid", 32'(rec.valid), 32'(want_valid));
		check_value("depth", 32'(depth), 32'(exp_depth));
		check_value("stack_error", 32'(stack_error), 32'(exp_err));
	end

	initial begin
		void'($urandom(32'h75ea));
		reset  <= 1'b1;
		retire <= '0;
		repeat (2) @(posedge clk);
		reset <= 1'b0;
		test_decode();
		test_nesting();
		test_back_to_back();
		test_guards();
		idle_one();
		while (exp_q.size() != 0) begin
			@(posedge clk);
		end
		repeat (4) @(posedge clk);
		if (dut0.prof0.sva0.assert_failed) begin
			$display("a bound assertion on the profiler failed");
			end_with_failure();
		end else begin
			$display("*** TEST PASSED ***");
			$finish;
		end
	end

endmodule

//--- profiler_top.f
prof_pkg.sv
call_decoder.sv
stack_ram.sv
counter_stack.sv
call_profiler.sv
profiler_top.sv
profiler_top_sva.sv
profiler_top_tb.sv

//--- run_sim.sh
#!/bin/sh
# build the call profiler testbench with Verilator, run it and check the log

cd "$(dirname "$0")" || exit 1
rm -rf obj_dir build.log sim.log

verilator --binary --timing --assert --top-module profiler_top_tb \
	-f profiler_top.f -o profiler_sim > build.log 2>&1 ||
	{ echo "build failed, see build.log"; exit 1; }

./obj_dir/profiler_sim > sim.log 2>&1

grep -qF "*** TEST PASSED ***" sim.log && { echo "simulation passed"; exit 0; } ||
	{ echo "simulation failed, see sim.log"; exit 1; }
